// File: zr_csr_stim.txt
# Columns are cmd f0 f1 f2 f3 f4, all hex, unused columns 0
# C op addr wdata old | D we dbg_addr wdata rdata | M ld st ungnt ld_tot st_tot | P halt resume halted | T gap delta | X dbg_addr dbg_wdata core_addr core_wdata rdata
C 1 340 a5a5f00f 0 0
C 2 340 0000ff00 a5a5f00f 0
C 3 340 a0000001 a5a5ff0f 0
C 0 340 0 05a5ff0e 0
C 2 300 ffffffff 0 0
C 0 300 0 8 0
C 3 300 8 8 0
C 0 300 0 0 0
C 1 341 12345677 0 0
C 0 341 0 12345674 0
C 1 f14 ffffffff 56a 0
C 0 f14 0 56a 0
C 1 123 ffffffff 0 0
C 0 123 0 0 0
D 1 4d00 cafef00d 05a5ff0e 0
C 0 340 0 cafef00d 0
D 0 4d04 0 12345674 0
D 0 7c50 0 56a 0
X 4d00 11112222 340 33334444 cafef00d
C 0 340 0 11112222 0
D 1 0 1 0 0
D 0 0 0 1 0
T 3 0 0 0 0
D 1 0 2 1 0
D 0 0 0 0 0
T 3 5 0 0 0
P 1 0 1 0 0
D 0 0 0 1 0
T 2 0 0 0 0
P 1 1 1 0 0
P 0 1 0 0 0
T 2 4 0 0 0
M 5 3 4 5 3
M 2 6 3 7 9
C 1 782 0 9 0
C 0 782 0 9 0

// File: zr_csr_subsystem.f
zr_csr_pkg.sv
zr_dbg_bus_slave.sv
zr_perf_counters.sv
zr_csr_regs.sv
zr_csr_subsystem.sv
tb_clk_gen.sv
tb_zr_csr_subsystem.sv

// File: tb_zr_csr_subsystem.sv
// Testbench for the CSR subsystem
// Replays command lines from zr_csr_stim.txt against the DUT,
// checks read data, debug handshake, halt state and counters

`timescale 1ns/1ps

module tb_zr_csr_subsystem
  import zr_csr_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;

  // Counter CSRs seen through the debug CSR region
  localparam dbg_addr_t DBG_LOADS  = {1'b1, CSR_PCCR_LOADS, 2'b00};
  localparam dbg_addr_t DBG_STORES = {1'b1, CSR_PCCR_STORES, 2'b00};

  logic       clk;
  logic       rst_n;
  logic [3:0] core_id;
  logic [5:0] cluster_id;
  csr_req_t   core_req;
  word_t      csr_rdata;
  logic       data_req;
  logic       data_gnt;
  logic       data_we;
  logic       irq_enable;
  word_t      mepc;
  logic       debug_req;
  logic       debug_gnt;
  logic       debug_rvalid;
  dbg_addr_t  debug_addr;
  logic       debug_we;
  word_t      debug_wdata;
  word_t      debug_rdata;
  logic       debug_halted;
  logic       debug_halt;
  logic       debug_resume;

  int          errors;
  int          checks;
  int          loads_total;
  int          stores_total;
  logic [31:0] rand_state;
  logic        irq_seen;
  word_t       mepc_seen;
  // Operand columns of the current stim line
  logic [31:0] f0;
  logic [31:0] f1;
  logic [31:0] f2;
  logic [31:0] f3;
  logic [31:0] f4;

  tb_clk_gen #(
    .PERIOD_NS    ( 8.0 ),
    .RESET_CYCLES ( 5   )
  ) clk_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  zr_csr_subsystem #(
    .COUNTER_WIDTH ( 32 )
  ) dut_i (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .core_id_i      ( core_id      ),
    .cluster_id_i   ( cluster_id   ),
    .core_csr_req_i ( core_req     ),
    .csr_rdata_o    ( csr_rdata    ),
    .data_req_i     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_we_i      ( data_we      ),
    .irq_enable_o   ( irq_enable   ),
    .mepc_o         ( mepc         ),
    .debug_req_i    ( debug_req    ),
    .debug_gnt_o    ( debug_gnt    ),
    .debug_rvalid_o ( debug_rvalid ),
    .debug_addr_i   ( debug_addr   ),
    .debug_we_i     ( debug_we     ),
    .debug_wdata_i  ( debug_wdata  ),
    .debug_rdata_o  ( debug_rdata  ),
    .debug_halted_o ( debug_halted ),
    .debug_halt_i   ( debug_halt   ),
    .debug_resume_i ( debug_resume )
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // LCG step returning the upper half
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, rand_state[31:16]};
  endfunction

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  // One-cycle core strobe with read data sampled mid-cycle
  task automatic core_access(input logic [1:0] op, input csr_addr_t addr,
                             input word_t wdata, output word_t rdata);
    @(posedge clk);
    core_req.access <= 1'b1;
    core_req.op     <= csr_op_e'(op);
    core_req.addr   <= addr;
    core_req.wdata  <= wdata;
    @(negedge clk);
    rdata     = csr_rdata;
    irq_seen  = irq_enable;
    mepc_seen = mepc;
    @(posedge clk);
    core_req.access <= 1'b0;
    core_req.op     <= CSR_OP_NONE;
  endtask

  // Single response expected one cycle after the grant
  task automatic wait_rvalid(input string name, output word_t rdata, output logic ok);
    int waited;
    ok     = 1'b0;
    rdata  = '0;
    waited = 0;
    while (!ok && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
      if (debug_rvalid) begin
        ok    = 1'b1;
        rdata = debug_rdata;
      end
    end
    checks++;
    if (!ok) begin
      report_error($sformatf("%s: timeout waiting for debug_rvalid_o", name));
    end else begin
      if (waited != 1) begin
        report_error($sformatf("%s: rvalid came %0d cycles after grant", name, waited));
      end
      @(negedge clk);
      checks++;
      if (debug_rvalid) begin
        report_error($sformatf("%s: debug_rvalid_o pulsed twice", name));
      end
    end
  endtask

  // Master holds req until gnt
  task automatic debug_access(input logic we, input dbg_addr_t addr, input word_t wdata,
                              input string name, output word_t rdata, output logic ok);
    int   waited;
    logic granted;
    @(posedge clk);
    debug_req   <= 1'b1;
    debug_we    <= we;
    debug_addr  <= addr;
    debug_wdata <= wdata;
    waited  = 0;
    granted = 1'b0;
    while (!granted && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
      granted = debug_gnt;
      if (!granted) begin
        @(posedge clk);
      end
    end
    @(posedge clk);
    debug_req <= 1'b0;
    debug_we  <= 1'b0;
    checks++;
    ok    = 1'b0;
    rdata = '0;
    if (!granted) begin
      report_error($sformatf("%s: timeout waiting for debug_gnt_o", name));
    end else begin
      if (waited != 1) begin
        report_error($sformatf("%s: grant took %0d cycles", name, waited));
      end
      wait_rvalid(name, rdata, ok);
    end
  endtask

  //////////////////////////////////////////////////
  // Command handlers
  //////////////////////////////////////////////////

  // C op addr wdata old_value
  task automatic check_core_op(input string name);
    word_t rd;
    core_access(f0[1:0], f1[11:0], f2, rd);
    checks++;
    if (rd !== f3) report_mismatch($sformatf("%s rdata", name), f3, rd);
    if (f0 == 0 && f1 == CSR_MSTATUS) begin
      checks++;
      if (irq_seen !== f3[MSTATUS_MIE_BIT]) begin
        report_mismatch($sformatf("%s irq_enable_o", name), f3[MSTATUS_MIE_BIT], irq_seen);
      end
    end
    if (f0 == 0 && f1 == CSR_MEPC) begin
      checks++;
      if (mepc_seen !== f3) report_mismatch($sformatf("%s mepc_o", name), f3, mepc_seen);
    end
  endtask

  // D we addr wdata rdata
  task automatic check_debug_op(input string name);
    word_t rd;
    logic  ok;
    debug_access(f0[0], f1[14:0], f2, name, rd, ok);
    if (ok) begin
      checks++;
      if (rd !== f3) report_mismatch($sformatf("%s debug_rdata_o", name), f3, rd);
    end
  endtask

  // M loads stores ungranted load_total store_total
  task automatic count_burst(input string name);
    int          nl;
    int          ns;
    int          nu;
    int          pick;
    logic [31:0] r;
    word_t       rd;
    logic        ok;
    nl = f0;
    ns = f1;
    nu = f2;
    while (nl + ns + nu > 0) begin
      r    = next_rand();
      pick = r % (nl + ns + nu);
      @(posedge clk);
      if (pick < nl) begin
        data_req <= 1'b1;
        data_gnt <= 1'b1;
        data_we  <= 1'b0;
        nl--;
        loads_total++;
      end else if (pick < nl + ns) begin
        data_req <= 1'b1;
        data_gnt <= 1'b1;
        data_we  <= 1'b1;
        ns--;
        stores_total++;
      end else begin
        // Request without grant, or grant without request
        data_req <= r[1];
        data_gnt <= ~r[1];
        data_we  <= r[2];
        nu--;
      end
    end
    @(posedge clk);
    data_req <= 1'b0;
    data_gnt <= 1'b0;
    data_we  <= 1'b0;
    checks++;
    if (loads_total != f3 || stores_total != f4) begin
      report_error($sformatf("%s: tracked totals disagree with stim totals", name));
    end
    debug_access(1'b0, DBG_LOADS, '0, name, rd, ok);
    checks++;
    if (ok && rd !== loads_total) report_mismatch($sformatf("%s loads", name), loads_total, rd);
    debug_access(1'b0, DBG_STORES, '0, name, rd, ok);
    checks++;
    if (ok && rd !== stores_total) begin
      report_mismatch($sformatf("%s stores", name), stores_total, rd);
    end
  endtask

  // P halt resume halted
  task automatic pulse_pins(input string name);
    @(posedge clk);
    debug_halt   <= f0[0];
    debug_resume <= f1[0];
    @(posedge clk);
    debug_halt   <= 1'b0;
    debug_resume <= 1'b0;
    @(negedge clk);
    checks++;
    if (debug_halted !== f2[0]) report_mismatch($sformatf("%s halted", name), f2, debug_halted);
  endtask

  // T gap delta
  // Two cycle counter reads gap+2 edges apart
  task automatic measure_cycles(input string name);
    word_t first;
    word_t second;
    word_t delta;
    core_access(CSR_OP_NONE, CSR_PCCR_CYCLES, '0, first);
    repeat (f0) @(posedge clk);
    core_access(CSR_OP_NONE, CSR_PCCR_CYCLES, '0, second);
    delta = second - first;
    checks++;
    if (delta !== f1) report_mismatch($sformatf("%s cycle delta", name), f1, delta);
  endtask

  // X dbg_addr dbg_wdata core_addr core_wdata rdata
  // Both writes land in the same cycle
  task automatic collide_writes(input string name);
    word_t rd;
    logic  ok;
    @(posedge clk);
    debug_req       <= 1'b1;
    debug_we        <= 1'b1;
    debug_addr      <= f0[14:0];
    debug_wdata     <= f1;
    core_req.access <= 1'b1;
    core_req.op     <= CSR_OP_WRITE;
    core_req.addr   <= f2[11:0];
    core_req.wdata  <= f3;
    @(negedge clk);
    rd = csr_rdata;
    checks++;
    if (!debug_gnt) report_error($sformatf("%s: no grant in collision cycle", name));
    checks++;
    if (rd !== f4) report_mismatch($sformatf("%s csr_rdata_o", name), f4, rd);
    @(posedge clk);
    debug_req       <= 1'b0;
    debug_we        <= 1'b0;
    core_req.access <= 1'b0;
    core_req.op     <= CSR_OP_NONE;
    wait_rvalid(name, rd, ok);
    if (ok) begin
      checks++;
      if (rd !== f4) report_mismatch($sformatf("%s debug_rdata_o", name), f4, rd);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int               fd;
    int               n;
    int               lineno;
    int               waited;
    logic [8*256-1:0] line;
    byte              cmd;
    string            name;

    errors       = 0;
    checks       = 0;
    loads_total  = 0;
    stores_total = 0;
    rand_state   = 32'h3c24;
    core_id      = 4'hA;
    cluster_id   = 6'h2B;
    core_req     = '0;
    data_req     = 1'b0;
    data_gnt     = 1'b0;
    data_we      = 1'b0;
    debug_req    = 1'b0;
    debug_we     = 1'b0;
    debug_addr   = '0;
    debug_wdata  = '0;
    debug_halt   = 1'b0;
    debug_resume = 1'b0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      report_error("reset was never released");
    end else begin
      // Reset values
      @(negedge clk);
      checks++;
      if ({debug_rvalid, debug_halted, irq_enable} !== 3'b000) begin
        report_mismatch("reset flags", '0, {debug_rvalid, debug_halted, irq_enable});
      end
      checks++;
      if (mepc !== '0) report_mismatch("reset mepc_o", '0, mepc);

      fd = $fopen("zr_csr_stim.txt", "r");
      if (fd == 0) begin
        report_error("cannot open zr_csr_stim.txt");
      end else begin
        lineno = 0;
        while (!$feof(fd)) begin
          line = '0;
          cmd  = 0;
          n    = $fgets(line, fd);
          lineno++;
          n = $sscanf(line, " %c %h %h %h %h %h", cmd, f0, f1, f2, f3, f4);
          if (n == 6 && cmd != "#") begin
            name = $sformatf("line %0d %c", lineno, cmd);
            // Random idle gap of 0 to 3 cycles
            repeat (next_rand() % 4) @(posedge clk);
            case (cmd)
              "C": check_core_op(name);
              "D": check_debug_op(name);
              "M": count_burst(name);
              "P": pulse_pins(name);
              "T": measure_cycles(name);
              "X": collide_writes(name);
              default: report_error($sformatf("%s: unknown command", name));
            endcase
          end
        end
        $fclose(fd);
      end
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock, active-low reset held for a fixed cycle count

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Release lands just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: zr_csr_subsystem.sv
// CSR subsystem top level
// Debug bus slave, performance counters and CSR register block,
// debug CSR accesses muxed into the core CSR path

`timescale 1ns/1ps

module zr_csr_subsystem
  import zr_csr_pkg::*;
#(
  parameter int unsigned COUNTER_WIDTH = PERF_CNT_WIDTH
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Static IDs
  input  logic [3:0] core_id_i,
  input  logic [5:0] cluster_id_i,

  // Core CSR port
  input  csr_req_t   core_csr_req_i,
  output word_t      csr_rdata_o,

  // Data bus events
  input  logic       data_req_i,
  input  logic       data_gnt_i,
  input  logic       data_we_i,

  // Interrupt control
  output logic       irq_enable_o,
  output word_t      mepc_o,

  // Debug bus
  input  logic       debug_req_i,
  output logic       debug_gnt_o,
  output logic       debug_rvalid_o,
  input  dbg_addr_t  debug_addr_i,
  input  logic       debug_we_i,
  input  word_t      debug_wdata_i,
  output word_t      debug_rdata_o,
  output logic       debug_halted_o,
  input  logic       debug_halt_i,
  input  logic       debug_resume_i
);

  csr_req_t  dbg_csr_req;
  perf_cnt_t perf_cnt;

  //////////////////////////////////////////////////
  // Debug slave
  //////////////////////////////////////////////////

  zr_dbg_bus_slave dbg_bus_slave_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .debug_req_i    ( debug_req_i    ),
    .debug_gnt_o    ( debug_gnt_o    ),
    .debug_rvalid_o ( debug_rvalid_o ),
    .debug_we_i     ( debug_we_i     ),
    .debug_addr_i   ( debug_addr_i   ),
    .debug_wdata_i  ( debug_wdata_i  ),
    .debug_rdata_o  ( debug_rdata_o  ),
    .debug_halt_i   ( debug_halt_i   ),
    .debug_resume_i ( debug_resume_i ),
    .debug_halted_o ( debug_halted_o ),
    .csr_req_o      ( dbg_csr_req    ),
    // Shared read data owned by debug when it accesses
    .csr_rdata_i    ( csr_rdata_o    )
  );

  // Cycle count frozen while halted
  zr_perf_counters #(
    .COUNTER_WIDTH ( COUNTER_WIDTH )
  ) perf_counters_i (
    .clk_i      ( clk_i          ),
    .rst_n_i    ( rst_n_i        ),
    .halted_i   ( debug_halted_o ),
    .data_req_i ( data_req_i     ),
    .data_gnt_i ( data_gnt_i     ),
    .data_we_i  ( data_we_i      ),
    .perf_cnt_o ( perf_cnt       )
  );

  //////////////////////////////////////////////////
  // CSR registers
  //////////////////////////////////////////////////

  zr_csr_regs #(
    .COUNTER_WIDTH ( COUNTER_WIDTH )
  ) csr_regs_i (
    .clk_i        ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .core_id_i    ( core_id_i      ),
    .cluster_id_i ( cluster_id_i   ),
    .core_req_i   ( core_csr_req_i ),
    .dbg_req_i    ( dbg_csr_req    ),
    .csr_rdata_o  ( csr_rdata_o    ),
    .perf_cnt_i   ( perf_cnt       ),
    .irq_enable_o ( irq_enable_o   ),
    .mepc_o       ( mepc_o         )
  );

endmodule

// File: zr_csr_regs.sv
// CSR register block
// Muxes debug over core requests, holds mstatus.MIE, mscratch and mepc,
// serves counters and hart ID; reads combinational, writes on the edge

`timescale 1ns/1ps

module zr_csr_regs
  import zr_csr_pkg::*;
#(
  parameter int unsigned COUNTER_WIDTH = PERF_CNT_WIDTH
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Static IDs
  input  logic [3:0] core_id_i,
  input  logic [5:0] cluster_id_i,

  // Requesters
  input  csr_req_t   core_req_i,
  input  csr_req_t   dbg_req_i,
  output word_t      csr_rdata_o,

  // Counter values
  input  perf_cnt_t  perf_cnt_i,

  // Interrupt control
  output logic       irq_enable_o,
  output word_t      mepc_o
);

  csr_req_t req;
  word_t    rdata;
  word_t    wdata_new;
  logic     wr_en;
  word_t    hartid;

  logic     mie_q;
  word_t    mscratch_q;
  word_t    mepc_q;

  //////////////////////////////////////////////////
  // Request arbitration
  //////////////////////////////////////////////////

  // Debug request takes the port in a collision
  assign req = dbg_req_i.access ? dbg_req_i : core_req_i;

  // Cluster in 10:5 and core in 3:0
  assign hartid = {21'b0, cluster_id_i, 1'b0, core_id_i};

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (req.addr)
      CSR_MSTATUS: begin
        rdata[MSTATUS_MIE_BIT] = mie_q;
      end
      CSR_MSCRATCH:    rdata = mscratch_q;
      CSR_MEPC:        rdata = mepc_q;
      // Narrow counters read zero-extended
      CSR_PCCR_CYCLES: rdata = word_t'(perf_cnt_i.cycles[COUNTER_WIDTH-1:0]);
      CSR_PCCR_LOADS:  rdata = word_t'(perf_cnt_i.loads[COUNTER_WIDTH-1:0]);
      CSR_PCCR_STORES: rdata = word_t'(perf_cnt_i.stores[COUNTER_WIDTH-1:0]);
      CSR_MHARTID:     rdata = hartid;
      default:         rdata = '0;
    endcase
  end

  // Old value visible in the request cycle
  assign csr_rdata_o = rdata;

  //////////////////////////////////////////////////
  // Write ops
  //////////////////////////////////////////////////

  always_comb begin
    wdata_new = rdata;
    wr_en     = req.access;
    case (req.op)
      CSR_OP_WRITE: wdata_new = req.wdata;
      CSR_OP_SET:   wdata_new = rdata | req.wdata;
      CSR_OP_CLEAR: wdata_new = rdata & ~req.wdata;
      default: begin
        // Plain read
        wr_en = 1'b0;
      end
    endcase
  end

  // Read-only and unmapped addresses fall through unchanged
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mie_q      <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (wr_en) begin
      case (req.addr)
        CSR_MSTATUS: begin
          mie_q <= wdata_new[MSTATUS_MIE_BIT];
        end
        CSR_MSCRATCH: begin
          mscratch_q <= wdata_new;
        end
        CSR_MEPC: begin
          // Word aligned return address
          mepc_q <= {wdata_new[31:2], 2'b00};
        end
        default: begin
        end
      endcase
    end
  end

  assign irq_enable_o = mie_q;
  assign mepc_o       = mepc_q;

endmodule

// File: zr_perf_counters.sv
// Performance counters
// Cycle count while running, plus granted loads and stores
// seen on the data bus, all wrapping

`timescale 1ns/1ps

module zr_perf_counters
  import zr_csr_pkg::*;
#(
  parameter int unsigned COUNTER_WIDTH = PERF_CNT_WIDTH
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Core state from the debug slave
  input  logic      halted_i,

  // Data bus handshake
  input  logic      data_req_i,
  input  logic      data_gnt_i,
  input  logic      data_we_i,

  output perf_cnt_t perf_cnt_o
);

  // Counter slots
  localparam int unsigned CNT_CYCLES = 0;
  localparam int unsigned CNT_LOADS  = 1;
  localparam int unsigned CNT_STORES = 2;
  localparam int unsigned N_CNT      = 3;

  logic                     data_xfer;
  logic [N_CNT-1:0]         cnt_inc;
  logic [COUNTER_WIDTH-1:0] cnt_q [N_CNT];

  //////////////////////////////////////////////////
  // Event detection
  //////////////////////////////////////////////////

  // Accepted transfer on the data bus
  assign data_xfer = data_req_i & data_gnt_i;

  assign cnt_inc[CNT_CYCLES] = ~halted_i;
  assign cnt_inc[CNT_LOADS]  = data_xfer & ~data_we_i;
  assign cnt_inc[CNT_STORES] = data_xfer & data_we_i;

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  // Count lands one cycle after the event
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (cnt_inc[i]) begin
          // Wraps at 2**COUNTER_WIDTH
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Zero-extend to the struct width
  assign perf_cnt_o.cycles = cnt_t'(cnt_q[CNT_CYCLES]);
  assign perf_cnt_o.loads  = cnt_t'(cnt_q[CNT_LOADS]);
  assign perf_cnt_o.stores = cnt_t'(cnt_q[CNT_STORES]);

endmodule

// File: zr_dbg_bus_slave.sv
// Debug bus slave
// Grants every request at once, returns read data one cycle later,
// runs the halt FSM and turns CSR-region accesses into CSR requests

`timescale 1ns/1ps

module zr_dbg_bus_slave
  import zr_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Debug bus
  input  logic      debug_req_i,
  output logic      debug_gnt_o,
  output logic      debug_rvalid_o,
  input  logic      debug_we_i,
  input  dbg_addr_t debug_addr_i,
  input  word_t     debug_wdata_i,
  output word_t     debug_rdata_o,

  // Halt control
  input  logic      debug_halt_i,
  input  logic      debug_resume_i,
  output logic      debug_halted_o,

  // CSR port towards the register block
  output csr_req_t  csr_req_o,
  input  word_t     csr_rdata_i
);

  dbg_state_e state_q, state_d;

  logic  csr_sel;
  logic  ctrl_sel;
  logic  ctrl_wr;
  logic  halt_req;
  logic  resume_req;
  word_t rdata_d;
  word_t rdata_q;
  logic  rvalid_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // No wait states on this slave
  assign debug_gnt_o = debug_req_i;

  assign csr_sel  = debug_addr_i[DBG_CSR_BIT];
  assign ctrl_sel = (debug_addr_i == DBG_CTRL_ADDR);
  assign ctrl_wr  = debug_req_i & ctrl_sel & debug_we_i;

  // Word address inside the CSR region
  always_comb begin
    csr_req_o.access = debug_req_i & csr_sel;
    csr_req_o.op     = debug_we_i ? CSR_OP_WRITE : CSR_OP_NONE;
    csr_req_o.addr   = csr_addr_t'(debug_addr_i[DBG_CSR_BIT-1:2]);
    csr_req_o.wdata  = debug_wdata_i;
  end

  //////////////////////////////////////////////////
  // Halt FSM
  //////////////////////////////////////////////////

  // Control word bit 0 halts and bit 1 resumes
  assign halt_req   = debug_halt_i | (ctrl_wr & debug_wdata_i[0]);
  assign resume_req = debug_resume_i | (ctrl_wr & debug_wdata_i[1]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      DBG_RUNNING: begin
        if (halt_req) begin
          state_d = DBG_HALTED;
        end
      end
      DBG_HALTED: begin
        // Halt has priority over resume
        if (resume_req && !halt_req) begin
          state_d = DBG_RUNNING;
        end
      end
      default: state_d = DBG_RUNNING;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DBG_RUNNING;
    end else begin
      state_q <= state_d;
    end
  end

  assign debug_halted_o = (state_q == DBG_HALTED);

  //////////////////////////////////////////////////
  // Read response
  //////////////////////////////////////////////////

  // Unmapped debug addresses read zero
  always_comb begin
    rdata_d = '0;
    if (csr_sel) begin
      rdata_d = csr_rdata_i;
    end else if (ctrl_sel) begin
      rdata_d[0] = debug_halted_o;
    end
  end

  // Rvalid follows each grant by exactly one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= debug_gnt_o;
    end
  end

  // Payload captured on grant only
  always_ff @(posedge clk_i) begin
    if (debug_gnt_o) begin
      rdata_q <= rdata_d;
    end
  end

  assign debug_rvalid_o = rvalid_q;
  assign debug_rdata_o  = rdata_q;

endmodule

// File: zr_csr_pkg.sv
// CSR subsystem package
// Widths, CSR addresses, op and debug state encodings,
// request and counter structs shared by all blocks

package zr_csr_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data word on CSR and debug buses
  typedef logic [31:0] word_t;
  // CSR address space
  typedef logic [11:0] csr_addr_t;
  // Debug bus byte address
  typedef logic [14:0] dbg_addr_t;

  // Default and maximum counter width
  localparam int unsigned PERF_CNT_WIDTH = 32;
  typedef logic [PERF_CNT_WIDTH-1:0] cnt_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic {
    DBG_RUNNING = 1'b0,
    DBG_HALTED  = 1'b1
  } dbg_state_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // Single-cycle CSR request of 47 bits
  typedef struct packed {
    logic      access;
    csr_op_e   op;
    csr_addr_t addr;
    word_t     wdata;
  } csr_req_t;

  // Counter values zero-extended to the full width
  typedef struct packed {
    cnt_t cycles;
    cnt_t loads;
    cnt_t stores;
  } perf_cnt_t;

  // CSR map
  localparam csr_addr_t CSR_MSTATUS     = 12'h300;
  localparam csr_addr_t CSR_MSCRATCH    = 12'h340;
  localparam csr_addr_t CSR_MEPC        = 12'h341;
  localparam csr_addr_t CSR_PCCR_CYCLES = 12'h780;
  localparam csr_addr_t CSR_PCCR_LOADS  = 12'h781;
  localparam csr_addr_t CSR_PCCR_STORES = 12'h782;
  localparam csr_addr_t CSR_MHARTID     = 12'hF14;

  // Global interrupt enable position in mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

  // Bit 14 of the debug address picks the CSR region
  localparam int unsigned DBG_CSR_BIT   = 14;
  localparam dbg_addr_t   DBG_CTRL_ADDR = 15'h0000;

endpackage
